//--- include/cpu_config.svh
// sizing and reset values for the pipelined processor
// included by the type package, the RTL and the testbench
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and instruction word width
`define CPU_WORD_W 32

// architectural registers, register zero reads as zero
`define CPU_REG_COUNT 32

// first fetch address after reset
`define CPU_PC_INIT 32'h0000_0000

// word address bits of the instruction and data memories in the testbench
`define CPU_MEM_AW 8

`endif

//--- source/cpu_types_pkg.sv
// instruction encodings, ALU and forwarding selects, and the stage payloads
// referenced by scoped names from the RTL and the testbench
`default_nettype none

`include "cpu_config.svh"

package cpu_types_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b,
		OP_HALT  = 6'h3f
	} opcode_t;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} alu_op_t;

	// source of an ALU operand in execute
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_EXMEM,
		FWD_MEMWB
	} fwd_sel_t;

	typedef struct packed {
		word_t instr;
		word_t pc_plus4;
	} if_id_t;

	typedef struct packed {
		logic     regwrite;
		logic     memread;
		logic     memwrite;
		logic     memtoreg;
		logic     alu_src_imm;
		logic     branch;
		logic     branch_ne;
		logic     halt;
		alu_op_t  alu_op;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t dst;
		word_t    rdat1;
		word_t    rdat2;
		word_t    imm;
		word_t    pc_plus4;
		logic [25:0] jaddr;
	} id_ex_t;

	typedef struct packed {
		logic     regwrite;
		logic     memread;
		logic     memwrite;
		logic     memtoreg;
		logic     halt;
		reg_idx_t dst;
		word_t    alu_result;
		word_t    store_data;
	} ex_mem_t;

	typedef struct packed {
		logic     regwrite;
		logic     memtoreg;
		reg_idx_t dst;
		word_t    alu_result;
		word_t    load_data;
	} mem_wb_t;

endpackage

`default_nettype wire

//--- source/alu.sv
// combinational ALU for the execute stage
// zero flag drives the beq and bne decision
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module alu (
	input  cpu_types_pkg::word_t   a,
	input  cpu_types_pkg::word_t   b,
	input  cpu_types_pkg::alu_op_t op,
	output cpu_types_pkg::word_t   result,
	output logic                   zero
);

	always_comb begin
		case (op)
			cpu_types_pkg::ALU_ADD: result = a + b;
			cpu_types_pkg::ALU_SUB: result = a - b;
			cpu_types_pkg::ALU_AND: result = a & b;
			cpu_types_pkg::ALU_OR:  result = a | b;
			// signed compare
			cpu_types_pkg::ALU_SLT:
				result = {{(`CPU_WORD_W-1){1'b0}}, ($signed(a) < $signed(b))};
			cpu_types_pkg::ALU_LUI: result = b << 16;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- source/control_unit.sv
// main decoder, turns the instruction in decode into control levels
// anything not recognised comes out as a no-op with all enables low
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  cpu_types_pkg::word_t   instr,
	output logic                   regwrite,
	output logic                   memread,
	output logic                   memwrite,
	output logic                   memtoreg,
	output logic                   alu_src_imm,
	output logic                   reg_dst_rd,
	output logic                   zero_ext,
	output logic                   branch,
	output logic                   branch_ne,
	output logic                   jump,
	output logic                   halt,
	output cpu_types_pkg::alu_op_t alu_op
);

	cpu_types_pkg::opcode_t opcode;
	cpu_types_pkg::funct_t  funct;

	assign opcode = cpu_types_pkg::opcode_t'(instr[31:26]);
	assign funct = cpu_types_pkg::funct_t'(instr[5:0]);

	always_comb begin
		regwrite = 1'b0;
		memread = 1'b0;
		memwrite = 1'b0;
		memtoreg = 1'b0;
		alu_src_imm = 1'b0;
		reg_dst_rd = 1'b0;
		zero_ext = 1'b0;
		branch = 1'b0;
		branch_ne = 1'b0;
		jump = 1'b0;
		halt = 1'b0;
		alu_op = cpu_types_pkg::ALU_ADD;
		case (opcode)
			cpu_types_pkg::OP_RTYPE: begin
				reg_dst_rd = 1'b1;
				regwrite = 1'b1;
				case (funct)
					cpu_types_pkg::FN_ADD: alu_op = cpu_types_pkg::ALU_ADD;
					cpu_types_pkg::FN_SUB: alu_op = cpu_types_pkg::ALU_SUB;
					cpu_types_pkg::FN_AND: alu_op = cpu_types_pkg::ALU_AND;
					cpu_types_pkg::FN_OR:  alu_op = cpu_types_pkg::ALU_OR;
					cpu_types_pkg::FN_SLT: alu_op = cpu_types_pkg::ALU_SLT;
					// unsupported funct, including the all-zero bubble
					default: regwrite = 1'b0;
				endcase
			end
			cpu_types_pkg::OP_ADDI: begin
				regwrite = 1'b1;
				alu_src_imm = 1'b1;
			end
			cpu_types_pkg::OP_ORI: begin
				regwrite = 1'b1;
				alu_src_imm = 1'b1;
				zero_ext = 1'b1;
				alu_op = cpu_types_pkg::ALU_OR;
			end
			cpu_types_pkg::OP_LUI: begin
				regwrite = 1'b1;
				alu_src_imm = 1'b1;
				alu_op = cpu_types_pkg::ALU_LUI;
			end
			cpu_types_pkg::OP_LW: begin
				regwrite = 1'b1;
				memread = 1'b1;
				memtoreg = 1'b1;
				alu_src_imm = 1'b1;
			end
			cpu_types_pkg::OP_SW: begin
				memwrite = 1'b1;
				alu_src_imm = 1'b1;
			end
			// branches compare through a subtract in execute
			cpu_types_pkg::OP_BEQ: begin
				branch = 1'b1;
				alu_op = cpu_types_pkg::ALU_SUB;
			end
			cpu_types_pkg::OP_BNE: begin
				branch = 1'b1;
				branch_ne = 1'b1;
				alu_op = cpu_types_pkg::ALU_SUB;
			end
			cpu_types_pkg::OP_J:    jump = 1'b1;
			cpu_types_pkg::OP_HALT: halt = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
// pipeline hazard control: load-use stall, branch and jump flush, and
// operand forwarding selects for execute
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  cpu_types_pkg::reg_idx_t id_rs,
	input  cpu_types_pkg::reg_idx_t id_rt,
	input  cpu_types_pkg::reg_idx_t ex_rs,
	input  cpu_types_pkg::reg_idx_t ex_rt,
	input  cpu_types_pkg::reg_idx_t ex_dst,
	input  logic                    ex_memread,
	input  logic                    ex_regwrite,
	input  cpu_types_pkg::reg_idx_t mem_dst,
	input  logic                    mem_regwrite,
	input  cpu_types_pkg::reg_idx_t wb_dst,
	input  logic                    wb_regwrite,
	input  logic                    branch_taken,
	input  logic                    jump,
	input  logic                    halted,
	output logic                    pc_stall,
	output logic                    if_id_stall,
	output logic                    if_id_flush,
	output logic                    id_ex_flush,
	output cpu_types_pkg::fwd_sel_t fwd_a,
	output cpu_types_pkg::fwd_sel_t fwd_b
);

	logic load_use;

	// the memory stage holds the younger result, so it wins over write-back
	function automatic cpu_types_pkg::fwd_sel_t pick_source(
		input cpu_types_pkg::reg_idx_t src
	);
		if (mem_regwrite && (mem_dst != '0) && (mem_dst == src))
			return cpu_types_pkg::FWD_EXMEM;
		if (wb_regwrite && (wb_dst != '0) && (wb_dst == src))
			return cpu_types_pkg::FWD_MEMWB;
		return cpu_types_pkg::FWD_REG;
	endfunction

	// load in execute feeding an instruction in decode
	assign load_use = ex_memread && ex_regwrite && (ex_dst != '0) &&
		((ex_dst == id_rs) || (ex_dst == id_rt));

	// a halt in memory freezes everything in front of it
	assign pc_stall = load_use || halted;
	assign if_id_stall = load_use || halted;

	// a jump held by a stall must not flush itself out of decode
	assign if_id_flush = !halted && (branch_taken || (jump && !load_use));
	assign id_ex_flush = !halted && (branch_taken || load_use);

	assign fwd_a = pick_source(ex_rs);
	assign fwd_b = pick_source(ex_rt);

endmodule

`default_nettype wire

//--- source/register_file.sv
// 32 x 32 register file, two combinational reads and one write
// a read of the register being written returns the write data
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module register_file (
	input  logic                    clk,
	input  logic                    reset,
	input  cpu_types_pkg::reg_idx_t rsel1,
	input  cpu_types_pkg::reg_idx_t rsel2,
	input  cpu_types_pkg::reg_idx_t wsel,
	input  logic                    wen,
	input  cpu_types_pkg::word_t    wdat,
	output cpu_types_pkg::word_t    rdat1,
	output cpu_types_pkg::word_t    rdat2
);

	cpu_types_pkg::word_t regs [`CPU_REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wen && (wsel != '0)) begin
			regs[wsel] <= wdat;
		end
	end

	// write-through lets write-back and decode share a cycle
	assign rdat1 = (rsel1 == '0) ? '0 :
		(wen && (wsel == rsel1)) ? wdat : regs[rsel1];
	assign rdat2 = (rsel2 == '0) ? '0 :
		(wen && (wsel == rsel2)) ? wdat : regs[rsel2];

endmodule

`default_nettype wire

//--- source/pipe_reg.sv
// one pipeline register between two stages, payload given as a type
// flush loads an empty payload and wins over stall
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     stall,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// all-zero payload has every enable low, so it travels as a bubble
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			q <= '0;
		end else if (!stall) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

//--- source/datapath.sv
// five-stage pipelined datapath for the 32-bit MIPS subset
// instruction and data memories sit outside, single-cycle with combinational read
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module datapath (
	input  logic                  clk,
	input  logic                  reset,
	output logic [`CPU_WORD_W-1:0] imem_addr,
	input  logic [`CPU_WORD_W-1:0] imem_load,
	output logic [`CPU_WORD_W-1:0] dmem_addr,
	output logic [`CPU_WORD_W-1:0] dmem_store,
	output logic                  dmem_ren,
	output logic                  dmem_wen,
	input  logic [`CPU_WORD_W-1:0] dmem_load,
	output logic                  halt
);

	cpu_types_pkg::word_t pc, pc_next, pc_plus4;
	cpu_types_pkg::if_id_t if_id_d, if_id_q;
	cpu_types_pkg::id_ex_t id_ex_d, id_ex_q;
	cpu_types_pkg::ex_mem_t ex_mem_d, ex_mem_q;
	cpu_types_pkg::mem_wb_t mem_wb_d, mem_wb_q;
	// decode
	logic c_regwrite, c_memread, c_memwrite, c_memtoreg, c_alu_src_imm;
	logic c_reg_dst_rd, c_zero_ext, c_branch, c_branch_ne, c_jump, c_halt;
	cpu_types_pkg::alu_op_t c_alu_op;
	cpu_types_pkg::reg_idx_t id_rs, id_rt, id_rd;
	cpu_types_pkg::word_t rdat1, rdat2, imm_ext, jump_target;
	// execute and write-back
	cpu_types_pkg::word_t op_a, op_b, alu_b, alu_result, branch_target, wb_data;
	logic alu_zero, branch_taken;
	cpu_types_pkg::fwd_sel_t fwd_a, fwd_b;
	logic pc_stall, if_id_stall, if_id_flush, id_ex_flush;

	function automatic cpu_types_pkg::word_t fwd_mux(
		input cpu_types_pkg::fwd_sel_t sel,
		input cpu_types_pkg::word_t    reg_val
	);
		case (sel)
			cpu_types_pkg::FWD_EXMEM: return ex_mem_q.alu_result;
			cpu_types_pkg::FWD_MEMWB: return wb_data;
			default:                  return reg_val;
		endcase
	endfunction

	// fetch
	always_ff @(posedge clk) begin
		if (reset)
			pc <= `CPU_PC_INIT;
		else if (!pc_stall)
			pc <= pc_next;
	end

	assign pc_plus4 = pc + 4;
	// older branch in execute beats a jump in decode
	assign pc_next = branch_taken ? branch_target : c_jump ? jump_target : pc_plus4;
	assign imem_addr = pc;
	assign if_id_d = '{instr: imem_load, pc_plus4: pc_plus4};

	// decode
	assign id_rs = if_id_q.instr[25:21];
	assign id_rt = if_id_q.instr[20:16];
	assign id_rd = if_id_q.instr[15:11];
	assign imm_ext = c_zero_ext ? {16'h0000, if_id_q.instr[15:0]}
		: {{16{if_id_q.instr[15]}}, if_id_q.instr[15:0]};
	assign jump_target = {if_id_q.pc_plus4[31:28], if_id_q.instr[25:0], 2'b00};

	control_unit control (
		.instr(if_id_q.instr), .regwrite(c_regwrite), .memread(c_memread),
		.memwrite(c_memwrite), .memtoreg(c_memtoreg), .alu_src_imm(c_alu_src_imm),
		.reg_dst_rd(c_reg_dst_rd), .zero_ext(c_zero_ext), .branch(c_branch),
		.branch_ne(c_branch_ne), .jump(c_jump), .halt(c_halt), .alu_op(c_alu_op)
	);

	register_file registers (
		.clk(clk), .reset(reset), .rsel1(id_rs), .rsel2(id_rt),
		.wsel(mem_wb_q.dst), .wen(mem_wb_q.regwrite), .wdat(wb_data),
		.rdat1(rdat1), .rdat2(rdat2)
	);

	assign id_ex_d = '{
		regwrite: c_regwrite, memread: c_memread, memwrite: c_memwrite,
		memtoreg: c_memtoreg, alu_src_imm: c_alu_src_imm, branch: c_branch,
		branch_ne: c_branch_ne, halt: c_halt, alu_op: c_alu_op,
		rs: id_rs, rt: id_rt, dst: c_reg_dst_rd ? id_rd : id_rt,
		rdat1: rdat1, rdat2: rdat2, imm: imm_ext,
		pc_plus4: if_id_q.pc_plus4, jaddr: if_id_q.instr[25:0]
	};

	// execute
	assign op_a = fwd_mux(fwd_a, id_ex_q.rdat1);
	assign op_b = fwd_mux(fwd_b, id_ex_q.rdat2);
	assign alu_b = id_ex_q.alu_src_imm ? id_ex_q.imm : op_b;
	assign branch_target = id_ex_q.pc_plus4 + {id_ex_q.imm[29:0], 2'b00};
	assign branch_taken = id_ex_q.branch && (alu_zero ^ id_ex_q.branch_ne);

	alu alu_ex (.a(op_a), .b(alu_b), .op(id_ex_q.alu_op), .result(alu_result), .zero(alu_zero));

	// store data is the forwarded rt value, never the immediate
	assign ex_mem_d = '{
		regwrite: id_ex_q.regwrite, memread: id_ex_q.memread,
		memwrite: id_ex_q.memwrite, memtoreg: id_ex_q.memtoreg, halt: id_ex_q.halt,
		dst: id_ex_q.dst, alu_result: alu_result, store_data: op_b
	};

	// memory
	assign dmem_addr = ex_mem_q.alu_result;
	assign dmem_store = ex_mem_q.store_data;
	assign dmem_ren = ex_mem_q.memread;
	assign dmem_wen = ex_mem_q.memwrite;
	assign halt = ex_mem_q.halt;
	assign mem_wb_d = '{
		regwrite: ex_mem_q.regwrite, memtoreg: ex_mem_q.memtoreg, dst: ex_mem_q.dst,
		alu_result: ex_mem_q.alu_result, load_data: dmem_load
	};

	// write-back
	assign wb_data = mem_wb_q.memtoreg ? mem_wb_q.load_data : mem_wb_q.alu_result;

	hazard_unit hazard (
		.id_rs(id_rs), .id_rt(id_rt), .ex_rs(id_ex_q.rs), .ex_rt(id_ex_q.rt),
		.ex_dst(id_ex_q.dst), .ex_memread(id_ex_q.memread),
		.ex_regwrite(id_ex_q.regwrite), .mem_dst(ex_mem_q.dst),
		.mem_regwrite(ex_mem_q.regwrite), .wb_dst(mem_wb_q.dst),
		.wb_regwrite(mem_wb_q.regwrite), .branch_taken(branch_taken),
		.jump(c_jump), .halted(halt), .pc_stall(pc_stall),
		.if_id_stall(if_id_stall), .if_id_flush(if_id_flush),
		.id_ex_flush(id_ex_flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	// halt sits in EX/MEM and holds it, write-back drains the halt bubble
	pipe_reg #(.payload_t(cpu_types_pkg::if_id_t)) if_id_reg (
		.clk(clk), .reset(reset), .stall(if_id_stall), .flush(if_id_flush),
		.d(if_id_d), .q(if_id_q)
	);
	pipe_reg #(.payload_t(cpu_types_pkg::id_ex_t)) id_ex_reg (
		.clk(clk), .reset(reset), .stall(halt), .flush(id_ex_flush),
		.d(id_ex_d), .q(id_ex_q)
	);
	pipe_reg #(.payload_t(cpu_types_pkg::ex_mem_t)) ex_mem_reg (
		.clk(clk), .reset(reset), .stall(halt), .flush(1'b0),
		.d(ex_mem_d), .q(ex_mem_q)
	);
	pipe_reg #(.payload_t(cpu_types_pkg::mem_wb_t)) mem_wb_reg (
		.clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0),
		.d(mem_wb_d), .q(mem_wb_q)
	);

endmodule

`default_nettype wire

//--- bench/datapath_assertions.sv
// concurrent checks on pipeline control, bound into the datapath
// by the testbench
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module datapath_assertions (
	input logic                    clk,
	input logic                    reset,
	input logic                    dmem_wen,
	input logic                    dmem_ren,
	input logic                    halt,
	input logic [`CPU_WORD_W-1:0]  imem_addr,
	input logic                    rf_wen,
	input cpu_types_pkg::reg_idx_t rf_wsel,
	input cpu_types_pkg::word_t    reg_zero
);

	// one memory stage, one access kind at a time
	mem_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(dmem_wen && dmem_ren))
		else $error("dmem_wen and dmem_ren high in the same cycle");

	halt_sticky: assert property (@(posedge clk) disable iff (reset) halt |=> halt)
		else $error("halt fell without reset");

	// fetch is frozen once halted
	fetch_frozen: assert property (@(posedge clk) disable iff (reset)
		halt |=> $stable(imem_addr))
		else $error("imem_addr moved after halt");

	zero_reg_fixed: assert property (@(posedge clk) disable iff (reset)
		(rf_wen && (rf_wsel == '0)) |=> (reg_zero == '0))
		else $error("write to register zero changed its value");

endmodule

`default_nettype wire

//--- bench/datapath_tb.sv
// testbench for the pipelined datapath: memory models, test programs,
// an in-order reference model of the ISA and a store checker
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module datapath_tb;

	localparam int MEM_WORDS = 1 << `CPU_MEM_AW;
	localparam int HALT_TIMEOUT = 2000;
	localparam int PROGRAMS = 6;

	logic clk, reset, dmem_ren, dmem_wen, halt;
	logic [`CPU_WORD_W-1:0] imem_addr, imem_load, dmem_addr, dmem_store, dmem_load;

	logic [`CPU_WORD_W-1:0] imem [MEM_WORDS];
	logic [`CPU_WORD_W-1:0] dmem [MEM_WORDS];
	logic [`CPU_WORD_W-1:0] exp_addr [$];
	logic [`CPU_WORD_W-1:0] exp_data [$];
	// memory-stage outputs sampled mid-cycle, committed on the next rising edge
	logic [`CPU_WORD_W-1:0] pend_addr, pend_data;
	logic pend_wen, pend_halt;
	logic [`CPU_MEM_AW-1:0] prog_len;
	integer seed;
	int store_idx, store_errors, check_errors;
	logic timed_out;

	datapath DUT (
		.clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_load(imem_load),
		.dmem_addr(dmem_addr), .dmem_store(dmem_store), .dmem_ren(dmem_ren),
		.dmem_wen(dmem_wen), .dmem_load(dmem_load), .halt(halt)
	);

	bind datapath datapath_assertions pipe_checks (
		.clk(clk), .reset(reset), .dmem_wen(dmem_wen), .dmem_ren(dmem_ren),
		.halt(halt), .imem_addr(imem_addr), .rf_wen(mem_wb_q.regwrite),
		.rf_wsel(mem_wb_q.dst), .reg_zero(registers.regs[0])
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// data memory contents after reset
	function automatic logic [`CPU_WORD_W-1:0] fill_word(input logic [`CPU_MEM_AW-1:0] a);
		return 32'h1f2e_3d4c ^ (32'h0101_0101 * 32'(a));
	endfunction

	function automatic logic [`CPU_WORD_W-1:0] rtype_word(
		input cpu_types_pkg::funct_t fn, input int rd, input int rs, input int rt
	);
		return {cpu_types_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [`CPU_WORD_W-1:0] itype_word(
		input cpu_types_pkg::opcode_t op, input int rt, input int rs, input logic [15:0] imm
	);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	// j and halt, target is a word index
	function automatic logic [`CPU_WORD_W-1:0] jtype_word(
		input cpu_types_pkg::opcode_t op, input int target
	);
		return {op, 26'(target)};
	endfunction

	task automatic emit_word(input logic [`CPU_WORD_W-1:0] w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	// in-order ISA model, collects every store up to halt
	function automatic void run_reference();
		logic [`CPU_WORD_W-1:0] regs [`CPU_REG_COUNT];
		logic [`CPU_WORD_W-1:0] mem [MEM_WORDS];
		logic [`CPU_WORD_W-1:0] pc, ins, a, b, imm_s, imm_z, addr;
		logic [4:0] rs, rt, rd;
		bit done;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < `CPU_REG_COUNT; i++)
			regs[i[4:0]] = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i[`CPU_MEM_AW-1:0]] = fill_word(i[`CPU_MEM_AW-1:0]);
		pc = `CPU_PC_INIT;
		done = 1'b0;
		for (int step = 0; step < 1000 && !done; step++) begin
			ins = imem[pc[`CPU_MEM_AW+1:2]];
			rs = ins[25:21];
			rt = ins[20:16];
			rd = ins[15:11];
			a = regs[rs];
			b = regs[rt];
			imm_s = {{16{ins[15]}}, ins[15:0]};
			imm_z = {16'h0000, ins[15:0]};
			addr = a + imm_s;
			pc = pc + 32'd4;
			case (cpu_types_pkg::opcode_t'(ins[31:26]))
				cpu_types_pkg::OP_RTYPE: begin
					case (cpu_types_pkg::funct_t'(ins[5:0]))
						cpu_types_pkg::FN_ADD: regs[rd] = a + b;
						cpu_types_pkg::FN_SUB: regs[rd] = a - b;
						cpu_types_pkg::FN_AND: regs[rd] = a & b;
						cpu_types_pkg::FN_OR:  regs[rd] = a | b;
						cpu_types_pkg::FN_SLT: regs[rd] = {31'd0, $signed(a) < $signed(b)};
						default: ;
					endcase
				end
				cpu_types_pkg::OP_ADDI: regs[rt] = a + imm_s;
				cpu_types_pkg::OP_ORI:  regs[rt] = a | imm_z;
				cpu_types_pkg::OP_LUI:  regs[rt] = {ins[15:0], 16'h0000};
				cpu_types_pkg::OP_LW:   regs[rt] = mem[addr[`CPU_MEM_AW+1:2]];
				cpu_types_pkg::OP_SW: begin
					exp_addr.push_back(addr);
					exp_data.push_back(b);
					mem[addr[`CPU_MEM_AW+1:2]] = b;
				end
				cpu_types_pkg::OP_BEQ: if (a == b) pc = pc + {imm_s[29:0], 2'b00};
				cpu_types_pkg::OP_BNE: if (a != b) pc = pc + {imm_s[29:0], 2'b00};
				cpu_types_pkg::OP_J:    pc = {pc[31:28], ins[25:0], 2'b00};
				cpu_types_pkg::OP_HALT: done = 1'b1;
				default: ;
			endcase
			regs[0] = '0;
		end
	endfunction

	task automatic build_program(input int kind);
		logic [`CPU_WORD_W-1:0] r1, r2, r3;
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		prog_len = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			imem[i[`CPU_MEM_AW-1:0]] = '0;
		case (kind)
			3: begin
				// each load is used by the very next instruction
				emit_word(itype_word(cpu_types_pkg::OP_LW, 1, 0, 16'd8));
				emit_word(rtype_word(cpu_types_pkg::FN_ADD, 2, 1, 1));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 2, 0, 16'd64));
				emit_word(itype_word(cpu_types_pkg::OP_LW, 3, 0, 16'd12));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 3, 0, 16'd68));
				emit_word(itype_word(cpu_types_pkg::OP_LW, 4, 0, 16'd16));
				emit_word(rtype_word(cpu_types_pkg::FN_SUB, 5, 3, 4));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 5, 0, 16'd72));
				emit_word(itype_word(cpu_types_pkg::OP_LW, 6, 0, 16'd64));
				emit_word(rtype_word(cpu_types_pkg::FN_OR, 7, 6, 5));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 7, 0, 16'd76));
				emit_word(jtype_word(cpu_types_pkg::OP_HALT, 0));
			end
			4: begin
				emit_word(itype_word(cpu_types_pkg::OP_ADDI, 1, 0, 16'd5));
				emit_word(itype_word(cpu_types_pkg::OP_ADDI, 2, 0, 16'd5));
				emit_word(itype_word(cpu_types_pkg::OP_ADDI, 3, 0, 16'd7));
				// taken beq to word 6, two shadow stores
				emit_word(itype_word(cpu_types_pkg::OP_BEQ, 2, 1, 16'd2));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 1, 0, 16'd100));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 2, 0, 16'd104));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 3, 0, 16'd108));
				emit_word(itype_word(cpu_types_pkg::OP_BNE, 2, 1, 16'd1));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 1, 0, 16'd112));
				// taken bne to word 12
				emit_word(itype_word(cpu_types_pkg::OP_BNE, 3, 1, 16'd2));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 1, 0, 16'd200));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 1, 0, 16'd204));
				emit_word(itype_word(cpu_types_pkg::OP_BEQ, 3, 1, 16'd1));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 3, 0, 16'd116));
				emit_word(jtype_word(cpu_types_pkg::OP_J, 16));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 1, 0, 16'd208));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 2, 0, 16'd120));
				// count down loop, backward bne to word 18
				emit_word(itype_word(cpu_types_pkg::OP_ADDI, 4, 0, 16'd3));
				emit_word(itype_word(cpu_types_pkg::OP_ADDI, 4, 4, 16'hffff));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 4, 0, 16'd124));
				emit_word(itype_word(cpu_types_pkg::OP_BNE, 0, 4, 16'hfffd));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 4, 0, 16'd128));
				emit_word(jtype_word(cpu_types_pkg::OP_HALT, 0));
			end
			5: begin
				// stores behind the halt must never reach memory
				emit_word(itype_word(cpu_types_pkg::OP_ADDI, 1, 0, 16'd9));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 1, 0, 16'd40));
				emit_word(jtype_word(cpu_types_pkg::OP_HALT, 0));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 1, 0, 16'd44));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 1, 0, 16'd48));
				emit_word(jtype_word(cpu_types_pkg::OP_HALT, 0));
			end
			default: begin
				// dependent chain, results one and two instructions old
				emit_word(itype_word(cpu_types_pkg::OP_LUI, 1, 0, r1[31:16]));
				emit_word(itype_word(cpu_types_pkg::OP_ORI, 1, 1, r1[15:0]));
				emit_word(itype_word(cpu_types_pkg::OP_LUI, 2, 0, r2[31:16]));
				emit_word(itype_word(cpu_types_pkg::OP_ORI, 2, 2, r2[15:0]));
				emit_word(itype_word(cpu_types_pkg::OP_ADDI, 3, 1, r3[15:0]));
				emit_word(rtype_word(cpu_types_pkg::FN_ADD, 4, 1, 2));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 4, 0, 16'd0));
				emit_word(rtype_word(cpu_types_pkg::FN_SUB, 5, 4, 3));
				emit_word(rtype_word(cpu_types_pkg::FN_AND, 6, 5, 4));
				emit_word(rtype_word(cpu_types_pkg::FN_OR, 7, 6, 5));
				emit_word(rtype_word(cpu_types_pkg::FN_SLT, 8, 7, 2));
				emit_word(rtype_word(cpu_types_pkg::FN_SLT, 9, 2, 7));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 5, 0, 16'd4));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 6, 0, 16'd8));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 7, 0, 16'd12));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 8, 0, 16'd16));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 9, 0, 16'd20));
				emit_word(itype_word(cpu_types_pkg::OP_ADDI, 10, 9, 16'hfffd));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 10, 0, 16'd24));
				// register zero as a destination, never written and never forwarded
				emit_word(itype_word(cpu_types_pkg::OP_ADDI, 0, 1, r3[15:0]));
				emit_word(itype_word(cpu_types_pkg::OP_SW, 0, 0, 16'd28));
				emit_word(jtype_word(cpu_types_pkg::OP_HALT, 0));
			end
		endcase
	endtask

	// memories answer from the addresses set up by the last rising edge
	initial begin
		imem_load = '0;
		dmem_load = '0;
		pend_wen = 1'b0;
		pend_halt = 1'b0;
		pend_addr = '0;
		pend_data = '0;
		forever begin
			@(negedge clk);
			imem_load = imem[imem_addr[`CPU_MEM_AW+1:2]];
			dmem_load = dmem[dmem_addr[`CPU_MEM_AW+1:2]];
			pend_wen = dmem_wen;
			pend_halt = halt;
			pend_addr = dmem_addr;
			pend_data = dmem_store;
		end
	end

	// store commit and comparison against the reference list
	always @(posedge clk) begin
		if (reset) begin
			store_idx = 0;
			for (int i = 0; i < MEM_WORDS; i++)
				dmem[i[`CPU_MEM_AW-1:0]] = fill_word(i[`CPU_MEM_AW-1:0]);
		end else if (pend_wen) begin
			assert (!pend_halt) else begin
				store_errors++;
				$display("ERR %0t store to %h while halt is high", $time, pend_addr);
			end
			assert (store_idx < exp_addr.size()) else begin
				store_errors++;
				$display("ERR %0t unexpected store %h <- %h", $time, pend_addr, pend_data);
			end
			if (store_idx < exp_addr.size()) begin
				assert ((pend_addr == exp_addr[store_idx]) && (pend_data == exp_data[store_idx]))
				else begin
					store_errors++;
					$display("ERR %0t store %0d: got %h <- %h, expected %h <- %h", $time,
						store_idx, pend_addr, pend_data, exp_addr[store_idx], exp_data[store_idx]);
				end
			end
			dmem[pend_addr[`CPU_MEM_AW+1:2]] = pend_data;
			store_idx++;
		end
	end

	task automatic check_reset_state();
		assert (!halt && !dmem_wen && !dmem_ren && (imem_addr == `CPU_PC_INIT)) else begin
			check_errors++;
			$display("ERR %0t reset state: halt %b wen %b ren %b imem_addr %h", $time,
				halt, dmem_wen, dmem_ren, imem_addr);
		end
	endtask

	task automatic run_program(input int kind);
		int cyc;
		@(negedge clk);
		reset = 1'b1;
		build_program(kind);
		run_reference();
		repeat (10) @(negedge clk);
		check_reset_state();
		reset = 1'b0;
		cyc = 0;
		while (!halt && (cyc < HALT_TIMEOUT)) begin
			@(negedge clk);
			cyc++;
		end
		if (!halt) begin
			$display("timeout: program %0d did not halt within %0d cycles", kind, HALT_TIMEOUT);
			timed_out = 1'b1;
		end else begin
			// halt must hold with no store behind it
			cyc = 0;
			while (cyc < 20) begin
				@(negedge clk);
				assert (halt) else begin
					check_errors++;
					$display("ERR %0t program %0d: halt dropped", $time, kind);
				end
				cyc++;
			end
			assert (store_idx == exp_addr.size()) else begin
				check_errors++;
				$display("ERR %0t program %0d made %0d stores, expected %0d", $time, kind,
					store_idx, exp_addr.size());
			end
		end
	endtask

	initial begin
		seed = 32'haffe;
		reset = 1'b1;
		store_errors = 0;
		check_errors = 0;
		timed_out = 1'b0;
		for (int k = 0; k < PROGRAMS; k++) begin
			if (!timed_out)
				run_program(k);
		end
		$display("errors: %0d store, %0d other, timeout %0d", store_errors, check_errors,
			timed_out);
		if (!timed_out && (store_errors == 0) && (check_errors == 0))
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
source/cpu_types_pkg.sv
source/alu.sv
source/control_unit.sv
source/hazard_unit.sv
source/register_file.sv
source/pipe_reg.sv
source/datapath.sv
bench/datapath_assertions.sv
bench/datapath_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = datapath_tb
FILELIST = src.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
